/* compile.f */
src/eth_rx_pkg.sv
src/rx_byte_if.sv
src/eth_rx_preamble.sv
src/eth_rx_fcs.sv
src/eth_rx_hdr.sv
src/eth_rx_top.sv
verification/eth_rx_checker.sv
verification/eth_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module eth_rx_tb -f compile.f &&
  ./obj_dir/Veth_rx_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test completed successfully" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

/* src/eth_rx_fcs.sv */
module eth_rx_fcs
  import eth_rx_pkg::*;
(
  input logic    clk,
  input logic    fsm_rst,
  rx_byte_if.snk in,
  rx_byte_if.src out
);

  // ********************************************************
  // Delay line and CRC
  // ********************************************************

  // dly[0] is the newest byte
  logic [FCS_LEN-1:0][7:0] dly;
  logic [2:0]              fill;
  logic                    line_full;

  logic [31:0] crc_q;
  logic [31:0] crc_d;
  logic        crc_bad;

  logic sof_pend;

  always_comb begin
    // CRC restarts on the first byte of a frame
    crc_d     = crc32_byte(in.sof ? CRC_INIT : crc_q, in.dat);
    crc_bad   = (crc_d != CRC_RESIDUE);
    line_full = !in.sof && (fill == 3'(FCS_LEN));
  end

  // ********************************************************
  // Release and flags
  // ********************************************************

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      fill     <= 3'd0;
      crc_q    <= CRC_INIT;
      sof_pend <= 1'b0;
      out.val  <= 1'b0;
      out.sof  <= 1'b0;
      out.eof  <= 1'b0;
      out.err  <= 1'b0;
    end else begin
      out.val <= 1'b0;
      out.sof <= 1'b0;
      out.eof <= 1'b0;
      out.err <= 1'b0;
      if (in.val) begin
        dly   <= {dly[FCS_LEN-2:0], in.dat};
        crc_q <= crc_d;

        if (in.sof) begin
          fill     <= 3'd1;
          sof_pend <= 1'b1;
        end else if (!line_full) begin
          fill <= fill + 3'd1;
        end

        // Oldest byte leaves once four newer ones are behind it
        if (line_full) begin
          out.val  <= 1'b1;
          out.dat  <= dly[FCS_LEN-1];
          out.sof  <= sof_pend;
          sof_pend <= 1'b0;
        end

        if (in.eof) begin
          fill    <= 3'd0;
          out.eof <= 1'b1;
          // Too short for any payload counts as a runt
          out.err <= !line_full || crc_bad || in.err;
        end
      end else if (in.eof) begin
        // Upstream ended with no byte at all
        fill    <= 3'd0;
        out.eof <= 1'b1;
        out.err <= 1'b1;
      end
    end
  end

endmodule

/* src/eth_rx_hdr.sv */
module eth_rx_hdr
  import eth_rx_pkg::*;
(
  input  logic        clk,
  input  logic        fsm_rst,
  rx_byte_if.snk      in,
  output logic        hdr_val,
  output mac_addr_t   dst_mac,
  output mac_addr_t   src_mac,
  output logic [15:0] ethertype,
  output logic [7:0]  dat,
  output logic        val,
  output logic        sof,
  output logic        eof,
  output logic        err
);

  mac_hdr_t hdr_q;
  mac_hdr_t hdr_d;

  // Header bytes seen so far, MAC_HDR_LEN means payload phase
  logic [3:0] hdr_cnt;
  logic [3:0] cnt_cur;
  logic       pay_first;

  always_comb begin
    cnt_cur     = in.sof ? 4'd0 : hdr_cnt;
    hdr_d.bytes = {hdr_q.bytes[MAC_HDR_LEN-2:0], in.dat};
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      hdr_cnt   <= 4'd0;
      pay_first <= 1'b0;
      hdr_val   <= 1'b0;
      val       <= 1'b0;
      sof       <= 1'b0;
      eof       <= 1'b0;
      err       <= 1'b0;
    end else begin
      hdr_val <= 1'b0;
      val     <= 1'b0;
      sof     <= 1'b0;
      eof     <= 1'b0;
      err     <= 1'b0;
      if (in.val) begin
        if (cnt_cur != 4'(MAC_HDR_LEN)) begin
          hdr_q   <= hdr_d;
          hdr_cnt <= cnt_cur + 4'd1;
          // Last header byte, present the fields
          if (cnt_cur == 4'(MAC_HDR_LEN - 1)) begin
            hdr_val   <= 1'b1;
            dst_mac   <= hdr_d.fields.dst_mac;
            src_mac   <= hdr_d.fields.src_mac;
            ethertype <= hdr_d.fields.ethertype;
            pay_first <= 1'b1;
          end
          // Frame ended before any payload
          if (in.eof) begin
            hdr_cnt <= 4'd0;
            eof     <= 1'b1;
            err     <= 1'b1;
          end
        end else begin
          val       <= 1'b1;
          dat       <= in.dat;
          sof       <= pay_first;
          eof       <= in.eof;
          err       <= in.eof && in.err;
          pay_first <= 1'b0;
          if (in.eof) begin
            hdr_cnt <= 4'd0;
          end
        end
      end else if (in.eof) begin
        // Runt flagged upstream
        hdr_cnt <= 4'd0;
        eof     <= 1'b1;
        err     <= 1'b1;
      end
    end
  end

endmodule

/* src/eth_rx_pkg.sv */
package eth_rx_pkg;

  // ********************************************************
  // Frame format constants
  // ********************************************************

  // Destination, source and ethertype
  localparam int MAC_HDR_LEN = 14;

  // Frame check sequence trails the payload
  localparam int FCS_LEN = 4;

  localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0] SFD_BYTE      = 8'hD5;

  // ********************************************************
  // CRC-32 constants
  // ********************************************************

  localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

  // Reflected polynomial, bits shifted in LSB first
  localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

  // Register value after data plus a correct FCS has been shifted in
  localparam logic [31:0] CRC_RESIDUE = 32'hDEBB_20E3;

  // ********************************************************
  // Header types
  // ********************************************************

  typedef logic [47:0] mac_addr_t;

  // Same 14 header bytes, seen as a shift register or as fields.
  // The first byte on the wire lands in bytes[MAC_HDR_LEN-1].
  typedef union packed {
    logic [MAC_HDR_LEN-1:0][7:0] bytes;
    struct packed {
      mac_addr_t   dst_mac;
      mac_addr_t   src_mac;
      logic [15:0] ethertype;
    } fields;
  } mac_hdr_t;

  // ********************************************************
  // CRC-32 byte update
  // ********************************************************

  function automatic logic [31:0] crc32_byte(
    input logic [31:0] crc,
    input logic [7:0]  data
  );
    logic [31:0] c;
    c = crc;
    // Bit 0 of the byte goes first, as on the wire
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ data[i]) begin
        c = (c >> 1) ^ CRC_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

endpackage

/* src/eth_rx_preamble.sv */
module eth_rx_preamble
  import eth_rx_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic [7:0] phy_dat,
  input  logic       phy_val,
  rx_byte_if.src     out
);

  localparam logic [1:0] ST_IDLE     = 2'd0;
  localparam logic [1:0] ST_PREAMBLE = 2'd1;
  localparam logic [1:0] ST_FRAME    = 2'd2;
  localparam logic [1:0] ST_DROP     = 2'd3;

  logic [1:0] state;

  // One byte held back so the last one can carry eof
  logic [7:0] hold_dat;
  logic       hold_vld;
  logic       first_pend;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state      <= ST_IDLE;
      hold_vld   <= 1'b0;
      first_pend <= 1'b0;
      out.val    <= 1'b0;
      out.sof    <= 1'b0;
      out.eof    <= 1'b0;
      out.err    <= 1'b0;
    end else begin
      out.val <= 1'b0;
      out.sof <= 1'b0;
      out.eof <= 1'b0;
      out.err <= 1'b0;
      case (state)
        ST_IDLE, ST_PREAMBLE: begin
          if (!phy_val) begin
            state <= ST_IDLE;
          end else if (phy_dat == PREAMBLE_BYTE) begin
            state <= ST_PREAMBLE;
          end else if (phy_dat == SFD_BYTE) begin
            state      <= ST_FRAME;
            hold_vld   <= 1'b0;
            first_pend <= 1'b1;
          end else begin
            state <= ST_DROP;
          end
        end
        ST_FRAME: begin
          if (phy_val) begin
            hold_dat <= phy_dat;
            hold_vld <= 1'b1;
            if (hold_vld) begin
              out.val    <= 1'b1;
              out.dat    <= hold_dat;
              out.sof    <= first_pend;
              first_pend <= 1'b0;
            end
          end else begin
            // End of frame, flush the held byte
            state    <= ST_IDLE;
            hold_vld <= 1'b0;
            out.val  <= hold_vld;
            out.dat  <= hold_dat;
            out.sof  <= first_pend && hold_vld;
            out.eof  <= 1'b1;
            out.err  <= !hold_vld;  // nothing after the SFD
          end
        end
        default: begin
          // Bad delimiter, wait for the gap
          if (!phy_val) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

endmodule

/* src/eth_rx_top.sv */
module eth_rx_top
  import eth_rx_pkg::*;
(
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic [7:0]  phy_dat,
  input  logic        phy_val,
  output logic        hdr_val,
  output mac_addr_t   dst_mac,
  output mac_addr_t   src_mac,
  output logic [15:0] ethertype,
  output logic [7:0]  dat,
  output logic        val,
  output logic        sof,
  output logic        eof,
  output logic        err
);

  // ********************************************************
  // Stage links
  // ********************************************************

  // Preamble stage to FCS stage
  rx_byte_if pre_to_fcs ();

  // FCS stage to header stage
  rx_byte_if fcs_to_hdr ();

  // ********************************************************
  // Receive pipeline
  // ********************************************************

  eth_rx_preamble preamble0 (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .phy_dat (phy_dat),
    .phy_val (phy_val),
    .out     (pre_to_fcs)
  );

  eth_rx_fcs fcs0 (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .in      (pre_to_fcs),
    .out     (fcs_to_hdr)
  );

  eth_rx_hdr hdr0 (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .in        (fcs_to_hdr),
    .hdr_val   (hdr_val),
    .dst_mac   (dst_mac),
    .src_mac   (src_mac),
    .ethertype (ethertype),
    .dat       (dat),
    .val       (val),
    .sof       (sof),
    .eof       (eof),
    .err       (err)
  );

endmodule

/* src/rx_byte_if.sv */
// Byte stream between the receive stages
interface rx_byte_if;

  logic [7:0] dat;
  logic       val;
  logic       sof;
  logic       eof;
  logic       err;

  modport src (
    output dat,
    output val,
    output sof,
    output eof,
    output err
  );

  modport snk (
    input dat,
    input val,
    input sof,
    input eof,
    input err
  );

endinterface

/* verification/eth_rx_checker.sv */
module eth_rx_checker (
  input logic clk,
  input logic fsm_rst,
  input logic hdr_val,
  input logic val,
  input logic sof,
  input logic eof,
  input logic err
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  logic seen_hdr;
  logic after_eof;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      seen_hdr  <= 1'b0;
      after_eof <= 1'b0;
    end else begin
      if (hdr_val) begin
        seen_hdr <= 1'b1;
      end
      // Empty payload gives eof in the hdr_val cycle
      if (eof) begin
        after_eof <= 1'b1;
      end else if (hdr_val) begin
        after_eof <= 1'b0;
      end
    end
  end

  quiet_until_hdr: assert property (@(posedge clk) disable iff (fsm_rst)
    (!seen_hdr && !hdr_val) |-> !(val || sof || eof || err))
    else begin
      fail_count++;
      $error("stream output before the first header");
    end

  flags_need_val: assert property (@(posedge clk) disable iff (fsm_rst)
    !val |-> (!sof && (!eof || err)))
    else begin
      fail_count++;
      $error("sof or eof without val outside a runt");
    end

  err_needs_eof: assert property (@(posedge clk) disable iff (fsm_rst)
    err |-> eof)
    else begin
      fail_count++;
      $error("err without eof");
    end

  no_val_between_frames: assert property (@(posedge clk) disable iff (fsm_rst)
    after_eof |-> !val)
    else begin
      fail_count++;
      $error("val between eof and the next header");
    end

endmodule

bind eth_rx_top eth_rx_checker checker0 (
  .clk     (clk),
  .fsm_rst (fsm_rst),
  .hdr_val (hdr_val),
  .val     (val),
  .sof     (sof),
  .eof     (eof),
  .err     (err)
);

/* verification/eth_rx_tb.sv */
module eth_rx_tb
  import eth_rx_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_FRAMES       = 60;
  localparam int CYCLES_PER_FRAME = 60;
  localparam int CLK_PERIOD       = 100;
  localparam int MAX_PAYLOAD      = 40;

  // Kinds of expected output events
  localparam int EV_HDR  = 0;
  localparam int EV_BYTE = 1;
  localparam int EV_RUNT = 2;

  logic        clk;
  logic        fsm_rst;
  logic [7:0]  phy_dat;
  logic        phy_val;
  logic        hdr_val;
  mac_addr_t   dst_mac;
  mac_addr_t   src_mac;
  logic [15:0] ethertype;
  logic [7:0]  dat;
  logic        val;
  logic        sof;
  logic        eof;
  logic        err;

  logic [15:0]  lfsr_state;
  int           exp_kind[$];
  logic [111:0] exp_data[$];

  eth_rx_top dut0 (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .phy_dat   (phy_dat),
    .phy_val   (phy_val),
    .hdr_val   (hdr_val),
    .dst_mac   (dst_mac),
    .src_mac   (src_mac),
    .ethertype (ethertype),
    .dat       (dat),
    .val       (val),
    .sof       (sof),
    .eof       (eof),
    .err       (err)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ********************************************************
  // Random source and reporting
  // ********************************************************

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic abort_run(input string why);
    $display("Error at %0t ns: %s", $time, why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input logic [111:0] actual, input logic [111:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // ********************************************************
  // Frame generator and reference model
  // ********************************************************

  task automatic send_frame(input int idx);
    logic [7:0]   frame_q[$];
    logic [7:0]   b;
    logic [111:0] hdr;
    logic [31:0]  crc;
    logic [31:0]  fcs;
    int           pre_len;
    int           pay_len;
    int           gap;
    logic         bad_sfd;
    logic         bad_fcs;

    pre_len = 1 + int'(rand_bits(3) % 7);
    pay_len = int'(rand_bits(6) % (MAX_PAYLOAD + 1));
    gap     = 2 + int'(rand_bits(2));
    bad_sfd = (rand_bits(3) == 0);
    bad_fcs = (rand_bits(3) == 0);
    // Keep a few empty payloads in the mix
    if (idx % 15 == 7) begin
      pay_len = 0;
    end

    repeat (pre_len) frame_q.push_back(PREAMBLE_BYTE);
    if (bad_sfd) begin
      // Bit 7 is never flipped so the byte cannot look like preamble
      b = 8'h01 << (rand_bits(3) % 7);
      frame_q.push_back(SFD_BYTE ^ b);
    end else begin
      frame_q.push_back(SFD_BYTE);
    end

    crc = CRC_INIT;
    hdr = '0;
    for (int i = 0; i < MAC_HDR_LEN; i++) begin
      b   = 8'(rand_bits(8));
      hdr = {hdr[103:0], b};
      crc = crc32_byte(crc, b);
      frame_q.push_back(b);
    end
    if (!bad_sfd) begin
      exp_kind.push_back(EV_HDR);
      exp_data.push_back(hdr);
      if (pay_len == 0) begin
        exp_kind.push_back(EV_RUNT);
        exp_data.push_back('0);
      end
    end

    for (int j = 0; j < pay_len; j++) begin
      b   = 8'(rand_bits(8));
      crc = crc32_byte(crc, b);
      frame_q.push_back(b);
      if (!bad_sfd) begin
        exp_kind.push_back(EV_BYTE);
        exp_data.push_back(112'({j == 0, j == pay_len - 1, bad_fcs && j == pay_len - 1, b}));
      end
    end

    // FCS is the inverted CRC sent low byte first
    fcs = ~crc;
    if (bad_fcs) begin
      fcs = fcs ^ (32'h1 << rand_bits(5));
    end
    for (int k = 0; k < FCS_LEN; k++) begin
      frame_q.push_back(fcs[8*k +: 8]);
    end

    foreach (frame_q[i]) begin
      @(negedge clk);
      phy_val = 1'b1;
      phy_dat = frame_q[i];
    end
    repeat (gap) begin
      @(negedge clk);
      phy_val = 1'b0;
      phy_dat = 8'h00;
    end
  endtask

  // ********************************************************
  // Output monitor
  // ********************************************************

  task automatic pop_event(input int kind_exp, input string where,
                           output logic [111:0] data);
    int kind;
    if (exp_kind.size() == 0) begin
      abort_run({"unexpected output at ", where, " with no frame pending"});
    end else begin
      kind = exp_kind.pop_front();
      data = exp_data.pop_front();
      check_value(112'(kind), 112'(kind_exp), {"event type at ", where});
    end
  endtask

  task automatic check_outputs();
    logic [111:0] data;
    if (hdr_val) begin
      pop_event(EV_HDR, "hdr_val", data);
      check_value({dst_mac, src_mac, ethertype}, data, "header fields");
    end
    if (val) begin
      pop_event(EV_BYTE, "val", data);
      check_value(112'({sof, eof, err, dat}), data, "payload byte and flags");
    end else if (sof || eof || err) begin
      pop_event(EV_RUNT, "runt eof", data);
      check_value(112'({sof, eof, err}), 112'(3'b011), "runt flags");
    end
  endtask

  always @(negedge clk) begin
    if (dut0.checker0.fail_count != 0) begin
      abort_run("an assertion in the checker failed");
    end else if (!fsm_rst) begin
      check_outputs();
    end
  end

  initial begin
    #(NUM_FRAMES * CYCLES_PER_FRAME * CLK_PERIOD);
    abort_run("watchdog expired before all frames were received");
  end

  initial begin
    clk        = 1'b0;
    fsm_rst    = 1'b1;
    phy_dat    = 8'h00;
    phy_val    = 1'b0;
    lfsr_state = 16'd14;
    repeat (3) @(posedge clk);
    @(negedge clk);
    fsm_rst = 1'b0;

    for (int f = 0; f < NUM_FRAMES; f++) begin
      send_frame(f);
    end
    while (exp_kind.size() != 0) begin
      @(negedge clk);
    end
    repeat (10) @(negedge clk);

    if (dut0.checker0.fail_count == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "assertion failures in the checker");
    end
  end

endmodule
